// File: rtl/fcvt_pkg.sv
//----------------------------------------------------------
// Shared widths and types for the binary32 <-> int32 converter
// Only binary32 and 32-bit integers are supported
//----------------------------------------------------------
package fcvt_pkg;

  // ----------------------------------------------------------
  // Widths
  // ----------------------------------------------------------
  localparam int unsigned FP_EXP_BITS = 8;
  localparam int unsigned FP_MAN_BITS = 23;
  localparam int unsigned FP_BIAS     = 127;
  localparam int unsigned INT_WIDTH   = 32;
  localparam int unsigned MANT_WIDTH  = 32; // Hidden bit + fraction, or a whole integer
  localparam int unsigned EXP_WIDTH   = 9;  // Down to the smallest subnormal, signed
  localparam int unsigned SHAMT_WIDTH = 5;  // Leading-zero count

  typedef logic        [INT_WIDTH-1:0]   word_t;  // Float pattern or integer
  typedef logic        [MANT_WIDTH-1:0]  mant_t;
  typedef logic signed [EXP_WIDTH-1:0]   exp_t;
  typedef logic        [SHAMT_WIDTH-1:0] shamt_t;

  typedef enum logic {F2I, I2F} operation_e;

  // RISC-V rounding mode encodings
  typedef enum logic [2:0] {
    RNE = 3'd0,
    RTZ = 3'd1,
    RDN = 3'd2,
    RUP = 3'd3,
    RMM = 3'd4
  } roundmode_e;

  // Status flags, MSB first NV DZ OF UF NX
  typedef logic [4:0] status_t;
  localparam int unsigned NV_BIT = 4;
  localparam int unsigned DZ_BIT = 3;
  localparam int unsigned OF_BIT = 2;
  localparam int unsigned UF_BIT = 1;
  localparam int unsigned NX_BIT = 0;

  // Class flags of a float operand
  typedef logic [5:0] fp_class_t;
  localparam int unsigned CLS_ZERO      = 5;
  localparam int unsigned CLS_SUBNORMAL = 4;
  localparam int unsigned CLS_INF       = 3;
  localparam int unsigned CLS_NAN       = 2;
  localparam int unsigned CLS_SNAN      = 1;
  localparam int unsigned CLS_NORMAL    = 0;

endpackage

// File: rtl/fcvt_norm_if.sv
//----------------------------------------------------------
// One normalized operand between converter stages
// Transfer when valid and ready are both high
//----------------------------------------------------------
`timescale 1ns/100ps

interface fcvt_norm_if;
  logic                  sign;
  fcvt_pkg::exp_t        exp;      // Unbiased true exponent
  fcvt_pkg::exp_t        dst_exp;  // Rebiased for binary32
  fcvt_pkg::mant_t       mant;     // Normalized, MSB set unless zero
  logic                  mant_zero;
  fcvt_pkg::fp_class_t   fp_class; // Cleared for integer sources
  fcvt_pkg::operation_e  op;
  logic                  op_mod;   // Unsigned integer side
  fcvt_pkg::roundmode_e  rnd_mode;
  logic                  valid;
  logic                  ready;

  // Producer side
  modport src (output sign, exp, dst_exp, mant, mant_zero, fp_class,
               output op, op_mod, rnd_mode, valid, input ready);
  // Consumer side
  modport dst (input sign, exp, dst_exp, mant, mant_zero, fp_class,
               input op, op_mod, rnd_mode, valid, output ready);
endinterface

// File: rtl/fcvt_unpack.sv
//----------------------------------------------------------
// Combinational front end, no register
// F2I classifies binary32, I2F takes the integer magnitude
//----------------------------------------------------------
`timescale 1ns/100ps

module fcvt_unpack (
  input  fcvt_pkg::word_t      operand_i,
  input  fcvt_pkg::operation_e op_i,
  input  logic                 op_mod_i,
  input  fcvt_pkg::roundmode_e rnd_mode_i,
  input  logic                 in_valid_i,
  output logic                 in_ready_o,
  fcvt_norm_if.src             norm
);

  logic                               is_i2f;
  logic [fcvt_pkg::FP_EXP_BITS-1:0]   exp_field;
  logic [fcvt_pkg::FP_MAN_BITS-1:0]   frac;
  fcvt_pkg::fp_class_t                cls;
  fcvt_pkg::mant_t                    fp_mant;
  logic                               int_sign;
  fcvt_pkg::word_t                    int_mag;
  fcvt_pkg::mant_t                    encoded_mant;
  fcvt_pkg::shamt_t                   lzc_cnt;
  fcvt_pkg::exp_t                     fp_exp, int_exp, true_exp;

  assign is_i2f    = (op_i == fcvt_pkg::I2F);
  assign exp_field = operand_i[fcvt_pkg::FP_MAN_BITS +: fcvt_pkg::FP_EXP_BITS];
  assign frac      = operand_i[fcvt_pkg::FP_MAN_BITS-1:0];

  // ----------------------------------------------------------
  // Float classification
  // ----------------------------------------------------------
  always_comb begin : classify
    cls                          = '0;
    cls[fcvt_pkg::CLS_ZERO]      = (exp_field == '0) && (frac == '0);
    cls[fcvt_pkg::CLS_SUBNORMAL] = (exp_field == '0) && (frac != '0);
    cls[fcvt_pkg::CLS_INF]       = (exp_field == '1) && (frac == '0);
    cls[fcvt_pkg::CLS_NAN]       = (exp_field == '1) && (frac != '0);
    cls[fcvt_pkg::CLS_SNAN]      = cls[fcvt_pkg::CLS_NAN] & ~frac[fcvt_pkg::FP_MAN_BITS-1];
    cls[fcvt_pkg::CLS_NORMAL]    = (exp_field != '0) && (exp_field != '1);
  end

  // Hidden bit only for normals, zero padded at the top
  assign fp_mant = fcvt_pkg::mant_t'({cls[fcvt_pkg::CLS_NORMAL], frac});

  // Signed integers give a magnitude, unsigned taken as is
  assign int_sign = operand_i[fcvt_pkg::INT_WIDTH-1] & ~op_mod_i;
  assign int_mag  = int_sign ? fcvt_pkg::word_t'(-operand_i) : operand_i;

  assign encoded_mant = is_i2f ? int_mag : fp_mant;

  // ----------------------------------------------------------
  // Normalization
  // ----------------------------------------------------------
  // Priority leading-zero count, highest set bit wins
  always_comb begin : lzc
    lzc_cnt = '0;
    for (int i = 0; i < fcvt_pkg::MANT_WIDTH; i++) begin
      if (encoded_mant[i]) lzc_cnt = fcvt_pkg::shamt_t'(fcvt_pkg::MANT_WIDTH - 1 - i);
    end
  end

  // Unbias, then undo the normalizing shift and the padding offset
  assign fp_exp   = fcvt_pkg::exp_t'({1'b0, exp_field})
                  + fcvt_pkg::exp_t'(cls[fcvt_pkg::CLS_SUBNORMAL]) // Subnormals use exponent 1
                  - fcvt_pkg::exp_t'(fcvt_pkg::FP_BIAS)
                  - fcvt_pkg::exp_t'({1'b0, lzc_cnt})
                  + fcvt_pkg::exp_t'(fcvt_pkg::MANT_WIDTH - 1 - fcvt_pkg::FP_MAN_BITS);
  assign int_exp  = fcvt_pkg::exp_t'(fcvt_pkg::MANT_WIDTH - 1) - fcvt_pkg::exp_t'({1'b0, lzc_cnt});
  assign true_exp = is_i2f ? int_exp : fp_exp;

  assign norm.sign      = is_i2f ? int_sign : operand_i[fcvt_pkg::INT_WIDTH-1];
  assign norm.exp       = true_exp;
  assign norm.dst_exp   = true_exp + fcvt_pkg::exp_t'(fcvt_pkg::FP_BIAS); // binary32 bias
  assign norm.mant      = encoded_mant << lzc_cnt;
  assign norm.mant_zero = (encoded_mant == '0);
  assign norm.fp_class  = is_i2f ? '0 : cls; // Integers carry no float class
  assign norm.op        = op_i;
  assign norm.op_mod    = op_mod_i;
  assign norm.rnd_mode  = rnd_mode_i;
  assign norm.valid     = in_valid_i;
  assign in_ready_o     = norm.ready;

endmodule

// File: rtl/fcvt_mid_reg.sv
//----------------------------------------------------------
// Elastic register holding one normalized operand
// flush_i drops the held item on the next edge
//----------------------------------------------------------
`timescale 1ns/100ps

module fcvt_mid_reg (
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     flush_i,
  fcvt_norm_if.dst up,
  fcvt_norm_if.src dn
);

  logic                 valid_q;
  logic                 reg_ena;
  logic                 sign_q;
  fcvt_pkg::exp_t       exp_q, dst_exp_q;
  fcvt_pkg::mant_t      mant_q;
  logic                 mant_zero_q;
  fcvt_pkg::fp_class_t  fp_class_q;
  fcvt_pkg::operation_e op_q;
  logic                 op_mod_q;
  fcvt_pkg::roundmode_e rnd_mode_q;

  // Accept when downstream takes our item or we only hold a bubble
  assign up.ready = dn.ready | ~valid_q;
  assign reg_ena  = up.ready & up.valid;

  always_ff @(posedge clk_i) begin
    if (rst_i || flush_i) begin
      valid_q <= 1'b0;
    end else if (up.ready) begin
      valid_q <= up.valid;
    end
  end

  // Payload, enable only
  always_ff @(posedge clk_i) begin
    if (reg_ena) begin
      sign_q      <= up.sign;
      exp_q       <= up.exp;
      dst_exp_q   <= up.dst_exp;
      mant_q      <= up.mant;
      mant_zero_q <= up.mant_zero;
      fp_class_q  <= up.fp_class;
      op_q        <= up.op;
      op_mod_q    <= up.op_mod;
      rnd_mode_q  <= up.rnd_mode;
    end
  end

  assign dn.sign      = sign_q;
  assign dn.exp       = exp_q;
  assign dn.dst_exp   = dst_exp_q;
  assign dn.mant      = mant_q;
  assign dn.mant_zero = mant_zero_q;
  assign dn.fp_class  = fp_class_q;
  assign dn.op        = op_q;
  assign dn.op_mod    = op_mod_q;
  assign dn.rnd_mode  = rnd_mode_q;
  assign dn.valid     = valid_q;

endmodule

// File: rtl/fcvt_cast_round.sv
//----------------------------------------------------------
// Cast, round, special cases and output register
// OF and UF stay low for 32-bit operands, binary32 covers them
//----------------------------------------------------------
`timescale 1ns/100ps

module fcvt_cast_round (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              flush_i,
  fcvt_norm_if.dst          norm,
  output fcvt_pkg::word_t   result_o,
  output fcvt_pkg::status_t status_o,
  output logic              out_valid_o,
  input  logic              out_ready_i,
  output logic              busy_o
);

  localparam int unsigned SHIFT_WIDTH    = 2 * fcvt_pkg::MANT_WIDTH + 1;
  localparam int unsigned DSH_WIDTH      = $clog2(fcvt_pkg::MANT_WIDTH + 1);
  localparam int unsigned NUM_FP_STICKY  = 2 * fcvt_pkg::MANT_WIDTH - fcvt_pkg::FP_MAN_BITS - 1;
  localparam int unsigned NUM_INT_STICKY = 2 * fcvt_pkg::MANT_WIDTH - fcvt_pkg::INT_WIDTH;

  logic                             dst_is_int;
  logic                             int_min;        // Exactly -2^31, still in range
  logic [fcvt_pkg::FP_EXP_BITS-1:0] final_exp;
  logic [SHIFT_WIDTH-1:0]           preshift_mant, destination_mant;
  logic [fcvt_pkg::FP_MAN_BITS-1:0] final_mant;
  fcvt_pkg::word_t                  final_int;
  logic [DSH_WIDTH-1:0]             denorm_shamt;
  logic [1:0]                       fp_rs, int_rs, rs;  // Round and sticky
  logic                             of_before_round, uf_before_round, of_after_round;
  fcvt_pkg::word_t                  pre_round_abs, rounded_abs, rounded_int_res;
  logic                             round_up;
  logic                             int_special;
  fcvt_pkg::word_t                  int_sat, int_special_res, int_result, fp_result;
  fcvt_pkg::word_t                  result_d, result_q;
  fcvt_pkg::status_t                status_d, status_q;
  logic                             out_valid_q;

  assign dst_is_int = (norm.op == fcvt_pkg::F2I);
  assign int_min    = ~norm.op_mod & norm.sign
                    & (norm.mant == {1'b1, {(fcvt_pkg::MANT_WIDTH-1){1'b0}}})
                    & (norm.exp == fcvt_pkg::exp_t'(fcvt_pkg::INT_WIDTH - 1));

  // ----------------------------------------------------------
  // Casting
  // ----------------------------------------------------------
  always_comb begin : cast_value
    final_exp       = norm.dst_exp[fcvt_pkg::FP_EXP_BITS-1:0];
    preshift_mant   = {norm.mant, {(fcvt_pkg::MANT_WIDTH+1){1'b0}}}; // Left of the shifter
    denorm_shamt    = '0;
    of_before_round = 1'b0;
    uf_before_round = 1'b0;
    if (dst_is_int) begin
      // Right shift into integer position
      denorm_shamt = DSH_WIDTH'(int'(fcvt_pkg::INT_WIDTH) - 1 - int'(norm.exp));
      // Unsigned range is one bit larger
      if (int'(norm.exp) >= int'(fcvt_pkg::INT_WIDTH) - 1 + int'(norm.op_mod) && !int_min) begin
        denorm_shamt    = '0;
        of_before_round = ~norm.mant_zero;
      end else if (int'(norm.exp) < -1) begin
        denorm_shamt    = DSH_WIDTH'(fcvt_pkg::INT_WIDTH + 1); // All into sticky
        uf_before_round = 1'b1;
      end
    end else begin
      if (int'(norm.dst_exp) >= int'(2 ** fcvt_pkg::FP_EXP_BITS) - 1) begin
        final_exp       = fcvt_pkg::FP_EXP_BITS'(2 ** fcvt_pkg::FP_EXP_BITS - 2); // Max normal
        preshift_mant   = '1;
        of_before_round = 1'b1;
      end else if (int'(norm.dst_exp) < 1 &&
                   int'(norm.dst_exp) >= -int'(fcvt_pkg::FP_MAN_BITS)) begin
        final_exp       = '0; // Subnormal result
        denorm_shamt    = DSH_WIDTH'(1 - int'(norm.dst_exp));
        uf_before_round = 1'b1;
      end else if (int'(norm.dst_exp) < -int'(fcvt_pkg::FP_MAN_BITS)) begin
        final_exp       = '0;
        denorm_shamt    = DSH_WIDTH'(fcvt_pkg::FP_MAN_BITS + 2); // Cap, keep sticky
        uf_before_round = 1'b1;
      end
    end
  end

  assign destination_mant = preshift_mant >> denorm_shamt;
  // Hidden bit dropped for float
  assign {final_mant, fp_rs[1]} =
      destination_mant[2*fcvt_pkg::MANT_WIDTH-1 -: fcvt_pkg::FP_MAN_BITS+1];
  assign {final_int, int_rs[1]} =
      destination_mant[2*fcvt_pkg::MANT_WIDTH -: fcvt_pkg::INT_WIDTH+1];
  assign fp_rs[0]  = |destination_mant[NUM_FP_STICKY-1:0];
  assign int_rs[0] = |destination_mant[NUM_INT_STICKY-1:0];
  assign rs        = dst_is_int ? int_rs : fp_rs;

  // ----------------------------------------------------------
  // Rounding
  // ----------------------------------------------------------
  assign pre_round_abs = dst_is_int ? final_int : {1'b0, final_exp, final_mant};

  always_comb begin : round_decide
    case (norm.rnd_mode)
      fcvt_pkg::RNE: round_up = rs[1] & (rs[0] | pre_round_abs[0]); // Ties to even
      fcvt_pkg::RTZ: round_up = 1'b0;
      fcvt_pkg::RDN: round_up = (|rs) & norm.sign;
      fcvt_pkg::RUP: round_up = (|rs) & ~norm.sign;
      fcvt_pkg::RMM: round_up = rs[1];                              // Ties away
      default:       round_up = 1'b0;
    endcase
  end

  assign rounded_abs     = pre_round_abs + fcvt_pkg::word_t'(round_up);
  assign of_after_round  = &rounded_abs[fcvt_pkg::FP_MAN_BITS +: fcvt_pkg::FP_EXP_BITS];
  assign rounded_int_res = norm.sign ? fcvt_pkg::word_t'(-rounded_abs) : rounded_abs;

  // Integer zero gives +0
  assign fp_result = norm.mant_zero ? '0
                   : {norm.sign, rounded_abs[fcvt_pkg::INT_WIDTH-2:0]};

  // ----------------------------------------------------------
  // Integer special cases
  // ----------------------------------------------------------
  assign int_special = norm.fp_class[fcvt_pkg::CLS_NAN] | norm.fp_class[fcvt_pkg::CLS_INF]
                     | of_before_round
                     | (norm.sign & norm.op_mod & (|rounded_int_res)); // Negative to unsigned

  assign int_sat         = {norm.op_mod, {(fcvt_pkg::INT_WIDTH-1){1'b1}}}; // Positive max
  assign int_special_res = (norm.sign & ~norm.fp_class[fcvt_pkg::CLS_NAN]) ? ~int_sat : int_sat;
  assign int_result      = int_special ? int_special_res : rounded_int_res;

  assign result_d = dst_is_int ? int_result : fp_result;

  always_comb begin : status_sel
    status_d                   = '0;
    status_d[fcvt_pkg::DZ_BIT] = 1'b0; // No division
    if (dst_is_int) begin
      status_d[fcvt_pkg::NV_BIT] = int_special;
      status_d[fcvt_pkg::NX_BIT] = ~int_special & (|int_rs);
    end else begin
      status_d[fcvt_pkg::OF_BIT] = of_before_round | of_after_round;
      status_d[fcvt_pkg::UF_BIT] = uf_before_round & (|fp_rs); // Tiny and inexact
      status_d[fcvt_pkg::NX_BIT] = (|fp_rs) | of_before_round | of_after_round;
    end
  end

  // ----------------------------------------------------------
  // Output register
  // ----------------------------------------------------------
  assign norm.ready = out_ready_i | ~out_valid_q;

  always_ff @(posedge clk_i) begin
    if (rst_i || flush_i) begin
      out_valid_q <= 1'b0;
    end else if (norm.ready) begin
      out_valid_q <= norm.valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (norm.ready && norm.valid) begin
      result_q <= result_d;
      status_q <= status_d;
    end
  end

  assign result_o    = result_q;
  assign status_o    = status_q;
  assign out_valid_o = out_valid_q;
  assign busy_o      = out_valid_q | norm.valid; // norm.valid is the mid register

endmodule

// File: rtl/fcvt_top.sv
//----------------------------------------------------------
// binary32 <-> int32 converter, two register stages
// Latency two edges, flush_i drops all items in flight
//----------------------------------------------------------
`timescale 1ns/100ps

module fcvt_top (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  fcvt_pkg::word_t      operand_i,
  input  fcvt_pkg::operation_e op_i,
  input  logic                 op_mod_i,   // 1 means unsigned integer
  input  fcvt_pkg::roundmode_e rnd_mode_i,
  input  logic                 in_valid_i,
  output logic                 in_ready_o,
  input  logic                 flush_i,
  output fcvt_pkg::word_t      result_o,
  output fcvt_pkg::status_t    status_o,
  output logic                 out_valid_o,
  input  logic                 out_ready_i,
  output logic                 busy_o
);

  fcvt_norm_if unpack_to_reg ();
  fcvt_norm_if reg_to_cast ();

  // Classify and normalize, combinational
  fcvt_unpack fcvt_unpack_inst (
    .operand_i  (operand_i),
    .op_i       (op_i),
    .op_mod_i   (op_mod_i),
    .rnd_mode_i (rnd_mode_i),
    .in_valid_i (in_valid_i),
    .in_ready_o (in_ready_o),
    .norm       (unpack_to_reg)
  );

  fcvt_mid_reg fcvt_mid_reg_inst (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .flush_i (flush_i),
    .up      (unpack_to_reg),
    .dn      (reg_to_cast)
  );

  // Cast and round into the output register
  fcvt_cast_round fcvt_cast_round_inst (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .flush_i     (flush_i),
    .norm        (reg_to_cast),
    .result_o    (result_o),
    .status_o    (status_o),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .busy_o      (busy_o)
  );

endmodule

// File: tb/tb_fcvt_checks.svh
//----------------------------------------------------------
// Typed compare tasks and counters for tb_fcvt
// Included inside the tb_fcvt module body
// err_cnt also counts timeouts and protocol errors
//----------------------------------------------------------
`ifndef TB_FCVT_CHECKS_SVH
`define TB_FCVT_CHECKS_SVH

int check_cnt = 0;  // Compares done
int err_cnt   = 0;  // Anything that went wrong

// Converted value against the trace
task automatic check_result(input int              idx,
                            input fcvt_pkg::word_t expected,
                            input fcvt_pkg::word_t actual);
  check_cnt++;
  if (actual !== expected) begin
    $display("Fail at %0t: result_o item %0d expected %h actual %h",
             $time, idx, expected, actual);
    err_cnt++;
  end
endtask

// Flags NV DZ OF UF NX against the trace
task automatic check_status(input int                idx,
                            input fcvt_pkg::status_t expected,
                            input fcvt_pkg::status_t actual);
  check_cnt++;
  if (actual !== expected) begin
    $display("Fail at %0t: status_o item %0d expected %b actual %b",
             $time, idx, expected, actual);
    err_cnt++;
  end
endtask

// One-bit output against its expected level
task automatic expect_bit(input string name,
                          input logic  expected,
                          input logic  actual);
  check_cnt++;
  if (actual !== expected) begin
    $display("Fail at %0t: %s expected %b actual %b", $time, name, expected, actual);
    err_cnt++;
  end
endtask

`endif

// File: tb/tb_fcvt.sv
//----------------------------------------------------------
// Items and expected values come from tb/fcvt_trace.txt
// Run from the project root so the trace path resolves
//----------------------------------------------------------
`timescale 1ns/100ps

module tb_fcvt;

  localparam int          CLK_PERIOD   = 8;
  localparam int          RESET_CYCLES = 8;
  localparam int          TIMEOUT      = 200;       // Cycles per wait
  localparam logic [31:0] SEED         = 32'd75251;
  // Trace index ranges
  localparam int          F2I_FIRST    = 0;
  localparam int          F2I_COUNT    = 12;
  localparam int          I2F_FIRST    = 12;
  localparam int          I2F_COUNT    = 11;
  localparam int          SPC_FIRST    = 23;
  localparam int          SPC_COUNT    = 11;
  localparam int          TRACE_ITEMS  = 34;

  logic                 clk_i = 1'b0;
  logic                 rst_i;
  fcvt_pkg::word_t      operand_i;
  fcvt_pkg::operation_e op_i;
  logic                 op_mod_i;
  fcvt_pkg::roundmode_e rnd_mode_i;
  logic                 in_valid_i;
  logic                 in_ready_o;
  logic                 flush_i;
  fcvt_pkg::word_t      result_o;
  fcvt_pkg::status_t    status_o;
  logic                 out_valid_o;
  logic                 out_ready_i;
  logic                 busy_o;

  // Trace contents with one entry per conversion
  logic                 tr_op[$];
  logic                 tr_mod[$];
  logic [2:0]           tr_rnd[$];
  fcvt_pkg::word_t      tr_operand[$];
  fcvt_pkg::word_t      tr_result[$];
  fcvt_pkg::status_t    tr_status[$];

  int                   exp_idx_q[$];   // Accepted items with the oldest first
  logic [31:0]          rng_state;
  logic                 bp_en;          // Random out_ready_i on
  int                   test_err_base;

  `include "tb_fcvt_checks.svh"

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  fcvt_top fcvt_top_inst (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .operand_i   (operand_i),
    .op_i        (op_i),
    .op_mod_i    (op_mod_i),
    .rnd_mode_i  (rnd_mode_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .flush_i     (flush_i),
    .result_o    (result_o),
    .status_o    (status_o),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .busy_o      (busy_o)
  );

  function automatic logic [31:0] next_random(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // ----------------------------------------------------------
  // Back-pressure and monitor
  // ----------------------------------------------------------
  always @(posedge clk_i) begin
    #1;
    if (bp_en) begin
      rng_state   = next_random(rng_state);
      out_ready_i = rng_state[3];
    end
  end

  // Sampled on the falling edge where inputs and outputs have settled
  always @(negedge clk_i) begin : monitor
    int idx;
    if (!rst_i) begin
      if (!in_ready_o && out_ready_i) begin
        $display("Error at %0t: in_ready_o low while out_ready_i is high", $time);
        err_cnt++;
      end
      if (out_valid_o && out_ready_i) begin  // Transfer on the coming edge
        if (exp_idx_q.size() == 0) begin
          $display("Error at %0t: an output appeared with no item pending", $time);
          err_cnt++;
        end else begin
          idx = exp_idx_q.pop_front();
          check_result(idx, tr_result[idx], result_o);
          check_status(idx, tr_status[idx], status_o);
        end
      end
    end
  end

  // ----------------------------------------------------------
  // Helper tasks
  // ----------------------------------------------------------
  task automatic end_run();
    $display("Checks %0d, errors %0d", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout at %0t after %0d cycles waiting for %s", $time, TIMEOUT, what);
    err_cnt++;
    end_run();
  endtask

  task automatic read_trace();
    int          fd;
    int          n;
    string       line;
    logic [31:0] f_op;
    logic [31:0] f_mod;
    logic [31:0] f_rnd;
    logic [31:0] f_opnd;
    logic [31:0] f_res;
    logic [31:0] f_st;
    fd = $fopen("tb/fcvt_trace.txt", "r");
    if (fd == 0) begin
      $display("Cannot open tb/fcvt_trace.txt from the working directory");
      err_cnt++;
      end_run();
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n    = $fgets(line, fd);
        if (n > 0 && line.getc(0) != "#") begin  // Skip comment lines
          n = $sscanf(line, "%h %h %h %h %h %h", f_op, f_mod, f_rnd, f_opnd, f_res, f_st);
          if (n == 6) begin
            tr_op.push_back(f_op[0]);
            tr_mod.push_back(f_mod[0]);
            tr_rnd.push_back(f_rnd[2:0]);
            tr_operand.push_back(f_opnd);
            tr_result.push_back(f_res);
            tr_status.push_back(f_st[4:0]);
          end
        end
      end
      $fclose(fd);
      if (tr_operand.size() != TRACE_ITEMS) begin
        $display("Trace holds %0d items instead of %0d", tr_operand.size(), TRACE_ITEMS);
        err_cnt++;
        end_run();
      end
    end
  endtask

  // Starts 1 ns after a rising edge and returns 1 ns after the accepting edge
  task automatic send_item(input int idx);
    int waited;
    waited     = 0;
    operand_i  = tr_operand[idx];
    op_i       = fcvt_pkg::operation_e'(tr_op[idx]);
    op_mod_i   = tr_mod[idx];
    rnd_mode_i = fcvt_pkg::roundmode_e'(tr_rnd[idx]);
    in_valid_i = 1'b1;
    @(negedge clk_i);
    while (!in_ready_o && waited < TIMEOUT) begin
      @(negedge clk_i);
      waited++;
    end
    if (!in_ready_o) begin
      report_timeout("in_ready_o");
    end else begin
      exp_idx_q.push_back(idx);
      @(posedge clk_i);
      #1;
      in_valid_i = 1'b0;
    end
  endtask

  // All expected items out and nothing left in flight
  task automatic wait_drain();
    int waited;
    waited = 0;
    @(negedge clk_i);
    while ((exp_idx_q.size() != 0 || busy_o) && waited < TIMEOUT) begin
      @(negedge clk_i);
      waited++;
    end
    if (exp_idx_q.size() != 0 || busy_o) begin
      report_timeout("the pipeline to drain");
    end else begin
      @(posedge clk_i);
      #1;
    end
  endtask

  task automatic run_range(input int first, input int count);
    for (int i = first; i < first + count; i++) begin
      send_item(i);
    end
    wait_drain();
  endtask

  task automatic finish_test(input string name);
    if (err_cnt == test_err_base) begin
      $display("Test %s: ok", name);
    end else begin
      $display("Test %s: %0d errors", name, err_cnt - test_err_base);
    end
    test_err_base = err_cnt;
  endtask

  // ----------------------------------------------------------
  // Tests
  // ----------------------------------------------------------
  task automatic check_latency();
    int out_edge;  // Coming edge counted from the accepting edge
    expect_bit("out_valid_o", 1'b0, out_valid_o);
    expect_bit("busy_o", 1'b0, busy_o);
    expect_bit("in_ready_o", 1'b1, in_ready_o);
    send_item(F2I_FIRST);
    @(negedge clk_i);
    out_edge = 1;
    while (!out_valid_o && out_edge < TIMEOUT) begin
      @(negedge clk_i);
      out_edge++;
    end
    if (!out_valid_o) begin
      report_timeout("out_valid_o");
    end else begin
      if (out_edge != 2) begin
        $display("Error at %0t: output on edge %0d after acceptance, not 2", $time, out_edge);
        err_cnt++;
      end
      wait_drain();
    end
  endtask

  task automatic check_flush();
    out_ready_i = 1'b0;      // Hold both items inside
    send_item(F2I_FIRST + 1);
    send_item(F2I_FIRST + 2);
    flush_i = 1'b1;
    @(posedge clk_i);
    #1;
    flush_i = 1'b0;
    exp_idx_q.delete();      // Dropped items never come out
    @(negedge clk_i);
    expect_bit("busy_o", 1'b0, busy_o);
    @(posedge clk_i);
    #1;
    out_ready_i = 1'b1;
    repeat (4) begin
      @(posedge clk_i);      // Monitor flags any stray output
    end
    #1;
    send_item(F2I_FIRST + 3);
    wait_drain();
  endtask

  initial begin : test_sequence
    $timeformat(-9, 0, " ns", 0);
    rst_i         = 1'b1;
    operand_i     = '0;
    op_i          = fcvt_pkg::F2I;
    op_mod_i      = 1'b0;
    rnd_mode_i    = fcvt_pkg::RNE;
    in_valid_i    = 1'b0;
    flush_i       = 1'b0;
    out_ready_i   = 1'b1;
    bp_en         = 1'b0;
    rng_state     = SEED;
    test_err_base = 0;
    read_trace();
    repeat (RESET_CYCLES) begin
      @(posedge clk_i);
    end
    #1;
    rst_i = 1'b0;

    check_latency();
    finish_test("latency_and_reset");
    run_range(F2I_FIRST, F2I_COUNT);
    finish_test("f2i_rounding");
    run_range(I2F_FIRST, I2F_COUNT);
    finish_test("i2f_conversion");
    run_range(SPC_FIRST, SPC_COUNT);
    finish_test("special_cases");

    bp_en = 1'b1;            // Whole trace under random back-pressure
    for (int i = 0; i < TRACE_ITEMS; i++) begin
      send_item(i);
    end
    bp_en       = 1'b0;
    out_ready_i = 1'b1;
    wait_drain();
    finish_test("back_pressure");

    check_flush();
    finish_test("flush");
    end_run();
  end

endmodule

// File: verilog.f
+incdir+tb
rtl/fcvt_pkg.sv
rtl/fcvt_norm_if.sv
rtl/fcvt_unpack.sv
rtl/fcvt_mid_reg.sv
rtl/fcvt_cast_round.sv
rtl/fcvt_top.sv
tb/tb_fcvt.sv

// File: tb/fcvt_trace.txt
# op op_mod rnd_mode operand result status, all hex, one conversion per line
# op 0 F2I 1 I2F; rnd 0 RNE 1 RTZ 2 RDN 3 RUP 4 RMM; status bits NV DZ OF UF NX
# F2I rounding, items 0 to 11
0 0 0 40200000 00000002 01
0 0 0 40600000 00000004 01
0 0 1 40200000 00000002 01
0 0 3 40200000 00000003 01
0 0 4 40200000 00000003 01
0 0 0 C0200000 FFFFFFFE 01
0 0 2 C0200000 FFFFFFFD 01
0 0 3 C0200000 FFFFFFFE 01
0 0 0 40300000 00000003 01
0 0 4 3F000000 00000001 01
0 1 1 42C80000 00000064 00
0 1 0 4F000000 80000000 00
# I2F, items 12 to 22
1 0 0 00000000 00000000 00
1 0 0 00000001 3F800000 00
1 0 0 FFFFFFFF BF800000 00
1 1 0 FFFFFFFF 4F800000 01
1 1 1 FFFFFFFF 4F7FFFFF 01
1 0 0 80000000 CF000000 00
1 1 0 80000000 4F000000 00
1 0 0 01000001 4B800000 01
1 0 4 01000001 4B800001 01
1 0 2 FEFFFFFF CB800001 01
1 0 0 7FFFFFFF 4F000000 01
# F2I special cases, items 23 to 33
0 0 0 7FC00000 7FFFFFFF 10
0 1 0 7F800001 FFFFFFFF 10
0 0 0 7F800000 7FFFFFFF 10
0 0 0 FF800000 80000000 10
0 1 0 FF800000 00000000 10
0 0 0 4F000000 7FFFFFFF 10
0 1 0 4F800000 FFFFFFFF 10
0 1 0 BFC00000 00000000 10
0 0 0 CF000000 80000000 00
0 0 0 80000000 00000000 00
0 0 0 00000001 00000000 01
